// ==== rv_alu.sv ====
// alu with operand b select, arithmetic and logic ops and the branch equality compare
`timescale 1ns/1ns

module rv_alu import rv_core_pkg::*; (
    input  ctrl_s           ctrl,
    input  logic [xlen-1:0] rs1_data,
    input  logic [xlen-1:0] rs2_data,
    input  logic [xlen-1:0] imm,
    output logic [xlen-1:0] alu_res,
    output logic            eq
);

    logic [xlen-1:0] src_a;
    logic [xlen-1:0] src_b;

    assign src_a = rs1_data;
    assign src_b = ctrl.use_imm ? imm : rs2_data;

    // branches compare the registers, never the immediate
    assign eq = (rs1_data == rs2_data);

    always_comb begin
        case (ctrl.alu_op)
            alu_add:    alu_res = src_a + src_b;
            alu_sub:    alu_res = src_a - src_b;
            alu_and:    alu_res = src_a & src_b;
            alu_or:     alu_res = src_a | src_b;
            alu_xor:    alu_res = src_a ^ src_b;
            alu_slt:    alu_res = {31'b0, $signed(src_a) < $signed(src_b)};
            alu_pass_b: alu_res = src_b;   // lui
            default:    alu_res = '0;
        endcase
    end

endmodule

// ==== rv_core.f ====
rv_core_pkg.sv
rv_perf_counter.sv
rv_imem.sv
rv_decoder.sv
rv_regfile.sv
rv_alu.sv
rv_ctrl_fsm.sv
rv_core_top.sv
tb_rv_core.sv

// ==== rv_core_pkg.sv ====
// rv core package with widths, rv32i encodings, alu ops, control struct and instruction views
package rv_core_pkg;

    localparam int xlen        = 32;
    localparam int reg_addr_w  = 5;
    localparam int imem_depth  = 64;   // instruction words
    localparam int imem_addr_w = 6;

    // opcodes kept in this core
    localparam logic [6:0] op_r      = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_system = 7'b1110011;

    // funct3 / funct7 values
    localparam logic [2:0] f3_add  = 3'b000;   // add, sub, addi
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;  // sub
    localparam logic [11:0] imm_ebreak = 12'h001;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b   // lui
    } alu_op_e;

    typedef struct packed {
        alu_op_e               alu_op;
        logic                  use_imm;    // operand b from immediate
        logic                  reg_wen;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic                  branch;
        logic                  branch_ne;  // bne rather than beq
        logic                  jump;
        logic                  halt;
    } ctrl_s;

    // four views of one instruction word
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_fmt;
    } rv_inst_u;

endpackage

// ==== rv_core_stimulus.txt ====
# P word: first program, R reg value: expected register, C n: retired, A addr: final pc
# Q word: second program with a bad opcode, N n: retired count of the second program
P 00c00093  # addi x1, x0, 12
P ffb00113  # addi x2, x0, -5
P 002081b3  # add  x3, x1, x2
P 40208233  # sub  x4, x1, x2
P 0020f2b3  # and  x5, x1, x2
P 0020e333  # or   x6, x1, x2
P 0020c3b3  # xor  x7, x1, x2
P 00112433  # slt  x8, x2, x1
P 0060f493  # andi x9, x1, 6
P 0030e513  # ori  x10, x1, 3
P fff0c593  # xori x11, x1, -1
P 12345637  # lui  x12, 0x12345
P 00108013  # addi x0, x1, 1
P 00300693  # addi x13, x0, 3
P 00270713  # loop: addi x14, x14, 2
P fff68693  # addi x13, x13, -1
P fe069ce3  # bne  x13, x0, loop
P 00068463  # beq  x13, x0, +8
P 06300793  # addi x15, x0, 99 (skipped)
P 0080086f  # jal  x16, +8
P 04d00793  # addi x15, x0, 77 (skipped)
P 00100073  # ebreak
R 0 00000000
R 1 0000000c
R 2 fffffffb
R 3 00000007
R 4 00000011
R 5 00000008
R 6 ffffffff
R 7 fffffff7
R 8 00000001
R 9 00000004
R 10 0000000f
R 11 fffffff3
R 12 12345000
R 13 00000000
R 14 00000006
R 15 00000000
R 16 00000050
C 26
A 00000054
Q 00500093  # addi x1, x0, 5
Q 00700113  # addi x2, x0, 7
Q 0000000b  # custom opcode, not supported
N 3

// ==== rv_core_top.sv ====
// multi-cycle rv32i subset core top with program load port, debug reads and counters
`timescale 1ns/1ns

module rv_core_top import rv_core_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic                   imem_we,
    input  logic [imem_addr_w-1:0] imem_addr,
    input  logic [xlen-1:0]        imem_wdata,
    input  logic [reg_addr_w-1:0]  dbg_raddr,
    output logic [xlen-1:0]        dbg_rdata,
    output logic [xlen-1:0]        pc,
    output logic                   halted,
    output logic                   unknown_code,
    output logic [31:0]            cycle_cnt,
    output logic [31:0]            instret_cnt
);

    rv_inst_u        inst;
    ctrl_s           ctrl;
    logic [xlen-1:0] imm;
    logic            unknown;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] alu_res;
    logic            eq;
    logic [xlen-1:0] link_pc;
    logic [xlen-1:0] wb_data;
    logic            wb_en;
    logic            retire;
    logic            running;

    assign wb_data = ctrl.jump ? link_pc : alu_res;   // jal writes pc+4

    rv_ctrl_fsm u_ctrl_fsm (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .start        ( start        ),
        .ctrl         ( ctrl         ),
        .imm          ( imm          ),
        .eq           ( eq           ),
        .unknown      ( unknown      ),
        .pc           ( pc           ),
        .link_pc      ( link_pc      ),
        .wb_en        ( wb_en        ),
        .retire       ( retire       ),
        .running      ( running      ),
        .halted       ( halted       ),
        .unknown_code ( unknown_code )
    );

    rv_perf_counter u_perf_counter (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .running     ( running     ),
        .retire      ( retire      ),
        .cycle_cnt   ( cycle_cnt   ),
        .instret_cnt ( instret_cnt )
    );

    rv_imem u_imem (
        .clk   ( clk        ),
        .we    ( imem_we    ),
        .waddr ( imem_addr  ),
        .wdata ( imem_wdata ),
        .raddr ( pc         ),
        .rdata ( inst       )
    );

    rv_decoder u_decoder (
        .inst    ( inst    ),
        .ctrl    ( ctrl    ),
        .imm     ( imm     ),
        .unknown ( unknown )
    );

    rv_regfile u_regfile (
        .clk       ( clk                  ),
        .rst_n     ( rst_n                ),
        .wen       ( wb_en & ctrl.reg_wen ),
        .waddr     ( ctrl.rd              ),
        .wdata     ( wb_data              ),
        .raddr1    ( ctrl.rs1             ),
        .raddr2    ( ctrl.rs2             ),
        .dbg_raddr ( dbg_raddr            ),
        .rdata1    ( rs1_data             ),
        .rdata2    ( rs2_data             ),
        .dbg_rdata ( dbg_rdata            )
    );

    rv_alu u_alu (
        .ctrl     ( ctrl     ),
        .rs1_data ( rs1_data ),
        .rs2_data ( rs2_data ),
        .imm      ( imm      ),
        .alu_res  ( alu_res  ),
        .eq       ( eq       )
    );

endmodule

// ==== rv_ctrl_fsm.sv ====
// control sequencer that steps fetch, execute and writeback and owns the pc and halt flags
`timescale 1ns/1ns

module rv_ctrl_fsm import rv_core_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  ctrl_s           ctrl,
    input  logic [xlen-1:0] imm,
    input  logic            eq,
    input  logic            unknown,
    output logic [xlen-1:0] pc,
    output logic [xlen-1:0] link_pc,
    output logic            wb_en,
    output logic            retire,
    output logic            running,
    output logic            halted,
    output logic            unknown_code
);

    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_exec,
        st_wb,
        st_halt
    } state_e;

    state_e          state;
    state_e          state_nxt;
    logic            taken;
    logic [xlen-1:0] pc_nxt;

    assign link_pc = pc + 32'd4;
    // beq wants eq, bne wants not eq
    assign taken   = ctrl.jump | (ctrl.branch & (eq ^ ctrl.branch_ne));
    assign pc_nxt  = taken ? pc + imm : link_pc;

    assign wb_en   = (state == st_wb);
    assign retire  = (state == st_wb);   // halting instructions retire too
    assign running = (state == st_fetch) | (state == st_exec) | (state == st_wb);

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle:  if (start) state_nxt = st_fetch;
            st_fetch: state_nxt = st_exec;    // imem read issued
            st_exec:  state_nxt = st_wb;      // decode and alu settle
            st_wb: begin
                if (ctrl.halt)
                    state_nxt = st_halt;
                else if (start)
                    state_nxt = st_fetch;
                else
                    state_nxt = st_idle;
            end
            st_halt:  state_nxt = st_halt;    // only reset leaves
            default:  state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= st_idle;
            pc           <= '0;
            halted       <= 1'b0;
            unknown_code <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == st_wb) begin
                if (!ctrl.halt)
                    pc <= pc_nxt;           // pc parks on ebreak when halting
                if (ctrl.halt)
                    halted <= 1'b1;
                if (unknown)
                    unknown_code <= 1'b1;
            end
        end
    end

endmodule

// ==== rv_decoder.sv ====
// instruction decoder from opcode and funct fields to control struct and sign-extended immediate
`timescale 1ns/1ns

module rv_decoder import rv_core_pkg::*; (
    input  rv_inst_u        inst,
    output ctrl_s           ctrl,
    output logic [xlen-1:0] imm,
    output logic            unknown
);

    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_j;
    logic [xlen-1:0] imm_u;

    assign imm_i = {{20{inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};
    assign imm_b = {{20{inst.b_fmt.imm12}}, inst.b_fmt.imm11, inst.b_fmt.imm10_5,
                    inst.b_fmt.imm4_1, 1'b0};
    assign imm_j = {{12{inst.j_fmt.imm20}}, inst.j_fmt.imm19_12, inst.j_fmt.imm11,
                    inst.j_fmt.imm10_1, 1'b0};
    // u immediate sits in the same bits 31:12 as the jal fields
    assign imm_u = {inst.j_fmt.imm20, inst.j_fmt.imm10_1, inst.j_fmt.imm11,
                    inst.j_fmt.imm19_12, 12'b0};

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = alu_add;
        ctrl.rd     = inst.r_fmt.rd;    // register fields share positions
        ctrl.rs1    = inst.r_fmt.rs1;
        ctrl.rs2    = inst.r_fmt.rs2;
        imm         = '0;
        unknown     = 1'b0;

        case (inst.r_fmt.opcode)
            op_r: begin
                ctrl.reg_wen = 1'b1;
                case ({inst.r_fmt.funct7, inst.r_fmt.funct3})
                    {f7_base, f3_add}: ctrl.alu_op = alu_add;
                    {f7_alt,  f3_add}: ctrl.alu_op = alu_sub;
                    {f7_base, f3_and}: ctrl.alu_op = alu_and;
                    {f7_base, f3_or}:  ctrl.alu_op = alu_or;
                    {f7_base, f3_xor}: ctrl.alu_op = alu_xor;
                    {f7_base, f3_slt}: ctrl.alu_op = alu_slt;
                    default:           unknown = 1'b1;
                endcase
            end
            op_imm: begin
                ctrl.reg_wen = 1'b1;
                ctrl.use_imm = 1'b1;
                imm          = imm_i;
                case (inst.i_fmt.funct3)
                    f3_add:  ctrl.alu_op = alu_add;
                    f3_and:  ctrl.alu_op = alu_and;
                    f3_or:   ctrl.alu_op = alu_or;
                    f3_xor:  ctrl.alu_op = alu_xor;
                    default: unknown = 1'b1;   // slti and shifts not kept
                endcase
            end
            op_lui: begin
                ctrl.reg_wen = 1'b1;
                ctrl.use_imm = 1'b1;
                ctrl.alu_op  = alu_pass_b;
                imm          = imm_u;
            end
            op_branch: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = alu_sub;
                imm         = imm_b;
                case (inst.b_fmt.funct3)
                    f3_beq:  ctrl.branch_ne = 1'b0;
                    f3_bne:  ctrl.branch_ne = 1'b1;
                    default: unknown = 1'b1;
                endcase
            end
            op_jal: begin
                ctrl.jump    = 1'b1;
                ctrl.reg_wen = 1'b1;   // link written from the fsm
                imm          = imm_j;
            end
            op_system: begin
                if (inst.i_fmt.imm12 == imm_ebreak && inst.i_fmt.rs1 == '0 &&
                    inst.i_fmt.funct3 == 3'b000 && inst.i_fmt.rd == '0)
                    ctrl.halt = 1'b1;
                else
                    unknown = 1'b1;
            end
            default: unknown = 1'b1;
        endcase

        // anything unrecognised stops the core with no side effects
        if (unknown) begin
            ctrl.halt    = 1'b1;
            ctrl.reg_wen = 1'b0;
            ctrl.branch  = 1'b0;
            ctrl.jump    = 1'b0;
        end
    end

endmodule

// ==== rv_imem.sv ====
// instruction memory with a load write port and a registered fetch read
`timescale 1ns/1ns

module rv_imem import rv_core_pkg::*; (
    input  logic                   clk,
    input  logic                   we,
    input  logic [imem_addr_w-1:0] waddr,
    input  logic [xlen-1:0]        wdata,
    input  logic [xlen-1:0]        raddr,
    output rv_inst_u               rdata
);

    logic [xlen-1:0]        mem [imem_depth];
    logic [imem_addr_w-1:0] ridx;

    assign ridx = raddr[imem_addr_w+1:2];   // byte pc to word index

    always_ff @(posedge clk) begin
        if (we)
            mem[waddr] <= wdata;
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        rdata <= mem[ridx];
    end

endmodule

// ==== rv_perf_counter.sv ====
// wrapping performance counters for active cycles and retired instructions
`timescale 1ns/1ns

module rv_perf_counter (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        running,
    input  logic        retire,
    output logic [31:0] cycle_cnt,
    output logic [31:0] instret_cnt
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_cnt <= '0;
        end else if (running) begin
            cycle_cnt <= cycle_cnt + 32'd1;
        end
    end

    // one count per writeback
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instret_cnt <= '0;
        end else if (retire) begin
            instret_cnt <= instret_cnt + 32'd1;
        end
    end

endmodule

// ==== rv_regfile.sv ====
// 32 x 32-bit register file with x0 reading zero, two operand ports and a debug port
`timescale 1ns/1ns

module rv_regfile import rv_core_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wen,
    input  logic [reg_addr_w-1:0] waddr,
    input  logic [xlen-1:0]       wdata,
    input  logic [reg_addr_w-1:0] raddr1,
    input  logic [reg_addr_w-1:0] raddr2,
    input  logic [reg_addr_w-1:0] dbg_raddr,
    output logic [xlen-1:0]       rdata1,
    output logic [xlen-1:0]       rdata2,
    output logic [xlen-1:0]       dbg_rdata
);

    logic [xlen-1:0] regs [2**reg_addr_w];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**reg_addr_w; i++)
                regs[i] <= '0;
        end else if (wen && waddr != '0) begin   // x0 never written
            regs[waddr] <= wdata;
        end
    end

    // combinational reads
    assign rdata1    = regs[raddr1];
    assign rdata2    = regs[raddr2];
    assign dbg_rdata = regs[dbg_raddr];

endmodule

// ==== tb_rv_core.sv ====
// rv core testbench that loads programs from the stimulus file, runs the core and checks results
`timescale 1ns/1ns

module tb_rv_core import rv_core_pkg::*; ();

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   start;
    logic                   imem_we;
    logic [imem_addr_w-1:0] imem_addr;
    logic [xlen-1:0]        imem_wdata;
    logic [reg_addr_w-1:0]  dbg_raddr;
    logic [xlen-1:0]        dbg_rdata;
    logic [xlen-1:0]        pc;
    logic                   halted;
    logic                   unknown_code;
    logic [31:0]            cycle_cnt;
    logic [31:0]            instret_cnt;

    // contents of the stimulus file
    logic [31:0] prog1[$];
    logic [31:0] prog2[$];
    int          exp_idx[$];
    logic [31:0] exp_val[$];
    int          exp_instret;
    int          exp2_instret;
    logic [31:0] exp_pc;
    bit          file_ok;

    int test_errs;
    int pass_cnt;
    int fail_cnt;

    rv_core_top u_dut (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .start        ( start        ),
        .imem_we      ( imem_we      ),
        .imem_addr    ( imem_addr    ),
        .imem_wdata   ( imem_wdata   ),
        .dbg_raddr    ( dbg_raddr    ),
        .dbg_rdata    ( dbg_rdata    ),
        .pc           ( pc           ),
        .halted       ( halted       ),
        .unknown_code ( unknown_code ),
        .cycle_cnt    ( cycle_cnt    ),
        .instret_cnt  ( instret_cnt  )
    );

    always #50 clk = ~clk;   // 100 ns period

    task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("CHECK FAILED at %0t ns: %s expected 0x%h, actual 0x%h", $time, sig, exp, act);
        test_errs++;
    endtask

    task automatic finish_test(input string name);
        if (test_errs == 0) begin
            pass_cnt++;
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: %0d error(s)", name, test_errs);
        end
        test_errs = 0;
    endtask

    task automatic read_stimulus();
        int          fd;
        int          ch;
        int          n;
        int          need;
        int          num;
        logic [31:0] word;
        bit          bad_rec;
        file_ok = 1'b0;
        bad_rec = 1'b0;
        fd = $fopen("rv_core_stimulus.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open rv_core_stimulus.txt");
        end else begin
            ch = $fgetc(fd);   // record letter
            while (ch != -1) begin
                n    = 0;
                need = 0;
                case (ch)
                    "P": begin
                        need = 1;
                        n    = $fscanf(fd, "%h", word);
                        prog1.push_back(word);
                    end
                    "Q": begin
                        need = 1;
                        n    = $fscanf(fd, "%h", word);
                        prog2.push_back(word);
                    end
                    "A": begin
                        need = 1;
                        n    = $fscanf(fd, "%h", exp_pc);
                    end
                    "R": begin
                        need = 2;
                        n    = $fscanf(fd, "%d %h", num, word);
                        exp_idx.push_back(num);
                        exp_val.push_back(word);
                    end
                    "C": begin
                        need = 1;
                        n    = $fscanf(fd, "%d", exp_instret);
                    end
                    "N": begin
                        need = 1;
                        n    = $fscanf(fd, "%d", exp2_instret);
                    end
                    default: ;   // comment or blank line
                endcase
                if (n != need)
                    bad_rec = 1'b1;
                while (ch != -1 && ch != "\n")   // rest of the line
                    ch = $fgetc(fd);
                ch = $fgetc(fd);
            end
            $fclose(fd);
            file_ok = !bad_rec && (prog1.size() > 0) && (prog2.size() > 0);
            if (!file_ok)
                $display("ERROR: stimulus file lacks program words or holds a malformed record");
        end
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        start = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
    endtask

    // write one program through the load port while start is low
    task automatic load_program(input int which);
        int          count;
        logic [31:0] word;
        count = (which == 1) ? prog1.size() : prog2.size();
        for (int i = 0; i < count; i++) begin
            word = (which == 1) ? prog1[i] : prog2[i];
            @(negedge clk);
            imem_we    = 1'b1;
            imem_addr  = imem_addr_w'(i);
            imem_wdata = word;
        end
        @(negedge clk);
        imem_we = 1'b0;
    endtask

    task automatic run_to_halt();
        int cycles;
        bit done;
        cycles = 0;
        done   = 1'b0;
        @(negedge clk);
        start = 1'b1;
        while (!done && cycles < 2000) begin
            @(negedge clk);
            cycles++;
            if (halted === 1'b1)
                done = 1'b1;
        end
        if (!done) begin
            $display("ERROR: core never halted within 2000 cycles, time %0t ns", $time);
            test_errs++;
        end
    endtask

    task automatic check_reset_values();
        @(negedge clk);
        if (halted !== 1'b0)
            report_mismatch("halted", 32'd0, {31'd0, halted});
        if (unknown_code !== 1'b0)
            report_mismatch("unknown_code", 32'd0, {31'd0, unknown_code});
        if (pc !== 32'd0)
            report_mismatch("pc", 32'd0, pc);
        if (cycle_cnt !== 32'd0)
            report_mismatch("cycle_cnt", 32'd0, cycle_cnt);
        if (instret_cnt !== 32'd0)
            report_mismatch("instret_cnt", 32'd0, instret_cnt);
    endtask

    initial begin
        rst_n      = 1'b0;
        start      = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        dbg_raddr  = '0;
        test_errs  = 0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        read_stimulus();
        if (!file_ok) begin
            fail_cnt++;
        end else begin
            apply_reset();
            check_reset_values();
            finish_test("reset_values");

            load_program(1);
            run_to_halt();
            for (int k = 0; k < exp_idx.size(); k++) begin
                @(negedge clk);
                dbg_raddr = reg_addr_w'(exp_idx[k]);
                #20;   // combinational debug read
                if (dbg_rdata !== exp_val[k])
                    report_mismatch($sformatf("x%0d", exp_idx[k]), exp_val[k], dbg_rdata);
            end
            finish_test("registers");

            if (halted !== 1'b1)
                report_mismatch("halted", 32'd1, {31'd0, halted});
            if (unknown_code !== 1'b0)
                report_mismatch("unknown_code", 32'd0, {31'd0, unknown_code});
            repeat (10) begin   // pc parked on the ebreak
                @(negedge clk);
                if (pc !== exp_pc)
                    report_mismatch("pc", exp_pc, pc);
            end
            finish_test("halt_state");

            if (instret_cnt !== exp_instret)
                report_mismatch("instret_cnt", exp_instret, instret_cnt);
            if (cycle_cnt !== 3 * exp_instret)
                report_mismatch("cycle_cnt", 3 * exp_instret, cycle_cnt);
            finish_test("counters");

            apply_reset();
            check_reset_values();
            finish_test("reset_values_rerun");

            load_program(2);
            run_to_halt();
            if (halted !== 1'b1)
                report_mismatch("halted", 32'd1, {31'd0, halted});
            if (unknown_code !== 1'b1)
                report_mismatch("unknown_code", 32'd1, {31'd0, unknown_code});
            if (instret_cnt !== exp2_instret)
                report_mismatch("instret_cnt", exp2_instret, instret_cnt);
            finish_test("unknown_opcode");
        end
        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule
